//--- Makefile
.PHONY: all run lint clean

all: run

obj_dir/Vcore_tb: riscv_core.f $(wildcard src/*.sv test/*.sv)
	verilator --binary --timing --assert -f riscv_core.f --top-module core_tb -o Vcore_tb

run: obj_dir/Vcore_tb
	./obj_dir/Vcore_tb | tee sim.log
	grep -q "Simulation passed" sim.log

lint:
	verilator --lint-only --timing -f riscv_core.f --top-module core_tb

clean:
	rm -rf obj_dir sim.log

//--- riscv_core.f
src/riscv_pkg.sv
src/control_unit.sv
src/register_file.sv
src/immediate_extender.sv
src/alu.sv
src/branch_decoder.sv
src/hazard_unit.sv
src/dataflow.sv
src/core_top.sv
test/tb_memory.sv
test/core_tb.sv

//--- src/alu.sv
`default_nettype none

module alu (
  input  riscv_pkg::word_t   a,
  input  riscv_pkg::word_t   b,
  input  riscv_pkg::alu_op_t alu_op,
  output riscv_pkg::word_t   y
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (alu_op)
      riscv_pkg::Add:   y = a + b;
      riscv_pkg::Sub:   y = a - b;
      riscv_pkg::Sll:   y = a << shamt;
      riscv_pkg::Slt:   y = {31'b0, $signed(a) < $signed(b)};
      riscv_pkg::Sltu:  y = {31'b0, a < b};
      riscv_pkg::Xor:   y = a ^ b;
      riscv_pkg::Srl:   y = a >> shamt;
      riscv_pkg::Sra:   y = $unsigned($signed(a) >>> shamt);
      riscv_pkg::Or:    y = a | b;
      riscv_pkg::And:   y = a & b;
      riscv_pkg::PassB: y = b;
      default:          y = a + b;
    endcase
  end

endmodule

`default_nettype wire

//--- src/branch_decoder.sv
`default_nettype none

module branch_decoder (
  input  riscv_pkg::branch_t      branch_type,
  input  riscv_pkg::cond_branch_t cond_branch_type,
  input  riscv_pkg::word_t        read_data_1,
  input  riscv_pkg::word_t        read_data_2,
  output riscv_pkg::pc_src_t      pc_src
);

  logic equal, less, less_unsigned, taken;

  assign equal = read_data_1 == read_data_2;
  assign less = $signed(read_data_1) < $signed(read_data_2);
  assign less_unsigned = read_data_1 < read_data_2;

  always_comb begin
    case (branch_type)
      riscv_pkg::JumpPc, riscv_pkg::JumpReg: taken = 1'b1;
      riscv_pkg::CondBranch: begin
        case (cond_branch_type)
          riscv_pkg::Beq:  taken = equal;
          riscv_pkg::Bne:  taken = ~equal;
          riscv_pkg::Blt:  taken = less;
          riscv_pkg::Bge:  taken = ~less;
          riscv_pkg::Bltu: taken = less_unsigned;
          riscv_pkg::Bgeu: taken = ~less_unsigned;
          default:         taken = 1'b0;
        endcase
      end
      default: taken = 1'b0;
    endcase
  end

  assign pc_src = taken ? riscv_pkg::PcPlusImm : riscv_pkg::PcPlus4;

endmodule

`default_nettype wire

//--- src/control_unit.sv
`default_nettype none

module control_unit (
  input  riscv_pkg::instruction_t inst,
  output riscv_pkg::control_t     control
);

  logic [2:0] funct3;

  assign funct3 = inst[14:12];

  // inst[30] selects SUB and SRA
  function automatic riscv_pkg::alu_op_t arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? riscv_pkg::Sub : riscv_pkg::Add;
      3'b001:  return riscv_pkg::Sll;
      3'b010:  return riscv_pkg::Slt;
      3'b011:  return riscv_pkg::Sltu;
      3'b100:  return riscv_pkg::Xor;
      3'b101:  return alt ? riscv_pkg::Sra : riscv_pkg::Srl;
      3'b110:  return riscv_pkg::Or;
      default: return riscv_pkg::And;
    endcase
  endfunction

  always_comb begin
    control = '0;
    case (riscv_pkg::opcode_t'(inst[6:0]))
      riscv_pkg::Lui: begin
        control.alub_src  = 1'b1;
        control.alu_op    = riscv_pkg::PassB;
        control.wr_reg_en = 1'b1;
      end
      riscv_pkg::Auipc: begin
        control.alua_src  = 1'b1;
        control.alub_src  = 1'b1;
        control.wr_reg_en = 1'b1;
      end
      riscv_pkg::Jal: begin
        control.branch_type = riscv_pkg::JumpPc;
        control.wr_reg_src  = riscv_pkg::FromPcPlus4;
        control.wr_reg_en   = 1'b1;
      end
      riscv_pkg::Jalr: begin
        control.branch_type = riscv_pkg::JumpReg;
        control.wr_reg_src  = riscv_pkg::FromPcPlus4;
        control.wr_reg_en   = 1'b1;
        control.uses_rs1    = 1'b1;
      end
      riscv_pkg::Branch: begin
        control.branch_type      = riscv_pkg::CondBranch;
        control.cond_branch_type = riscv_pkg::cond_branch_t'(funct3);
        control.uses_rs1         = 1'b1;
        control.uses_rs2         = 1'b1;
      end
      riscv_pkg::Load: begin
        control.alub_src   = 1'b1;
        control.mem_rd_en  = 1'b1;
        control.wr_reg_src = riscv_pkg::FromMem;
        control.wr_reg_en  = 1'b1;
        control.uses_rs1   = 1'b1;
      end
      riscv_pkg::Store: begin
        control.alub_src  = 1'b1;
        control.mem_wr_en = 1'b1;
        control.uses_rs1  = 1'b1;
        control.uses_rs2  = 1'b1;
      end
      riscv_pkg::OpImm: begin
        // Only SRAI carries the alternate bit, ADDI has no SUB form
        control.alub_src  = 1'b1;
        control.alu_op    = arith_op(funct3, funct3 == 3'b101 && inst[30]);
        control.wr_reg_en = 1'b1;
        control.uses_rs1  = 1'b1;
      end
      riscv_pkg::Op: begin
        control.alu_op    = arith_op(funct3, inst[30]);
        control.wr_reg_en = 1'b1;
        control.uses_rs1  = 1'b1;
        control.uses_rs2  = 1'b1;
      end
      default: begin
        control = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/core_top.sv
`default_nettype none

module core_top #(
  parameter riscv_pkg::word_t RESET_PC = '0
) (
  input  logic                    clock,
  input  logic                    reset,
  input  riscv_pkg::instruction_t inst,
  output riscv_pkg::word_t        inst_mem_addr,
  input  riscv_pkg::word_t        rd_data,
  output riscv_pkg::word_t        data_mem_addr,
  output riscv_pkg::word_t        wr_data,
  output logic                    rd_en,
  output logic                    wr_en,
  input  logic                    mem_busy
);

  riscv_pkg::control_t control;
  riscv_pkg::instruction_t id_inst;
  riscv_pkg::forward_t forward;
  riscv_pkg::hazard_view_t hazard_view;
  logic branch_taken, stall_if, stall_id, flush_id, flush_ex;

  dataflow #(
    .RESET_PC(RESET_PC)
  ) u_dataflow (
    .clock        (clock),
    .reset        (reset),
    .inst         (inst),
    .inst_mem_addr(inst_mem_addr),
    .rd_data      (rd_data),
    .data_mem_addr(data_mem_addr),
    .wr_data      (wr_data),
    .rd_en        (rd_en),
    .wr_en        (wr_en),
    .mem_busy     (mem_busy),
    .control      (control),
    .id_inst      (id_inst),
    .forward      (forward),
    .hazard_view  (hazard_view),
    .branch_taken (branch_taken),
    .stall_if     (stall_if),
    .stall_id     (stall_id),
    .flush_id     (flush_id),
    .flush_ex     (flush_ex)
  );

  control_unit u_control_unit (
    .inst   (id_inst),
    .control(control)
  );

  hazard_unit u_hazard_unit (
    .hazard_view (hazard_view),
    .branch_taken(branch_taken),
    .forward     (forward),
    .stall_if    (stall_if),
    .stall_id    (stall_id),
    .flush_id    (flush_id),
    .flush_ex    (flush_ex)
  );

endmodule

`default_nettype wire

//--- src/dataflow.sv
`default_nettype none

module dataflow #(
  parameter riscv_pkg::word_t RESET_PC = '0
) (
  input  logic                    clock,
  input  logic                    reset,
  input  riscv_pkg::instruction_t inst,
  output riscv_pkg::word_t        inst_mem_addr,
  input  riscv_pkg::word_t        rd_data,
  output riscv_pkg::word_t        data_mem_addr,
  output riscv_pkg::word_t        wr_data,
  output logic                    rd_en,
  output logic                    wr_en,
  input  logic                    mem_busy,
  input  riscv_pkg::control_t     control,
  output riscv_pkg::instruction_t id_inst,
  input  riscv_pkg::forward_t     forward,
  output riscv_pkg::hazard_view_t hazard_view,
  output logic                    branch_taken,
  input  logic                    stall_if,
  input  logic                    stall_id,
  input  logic                    flush_id,
  input  logic                    flush_ex
);

  riscv_pkg::if_id_t if_id;
  riscv_pkg::id_ex_t id_ex;
  riscv_pkg::ex_mem_t ex_mem;
  riscv_pkg::mem_wb_t mem_wb;

  riscv_pkg::word_t pc, pc_plus_4, imm, jump_sum, branch_target;
  riscv_pkg::word_t rs1_value, rs2_value, rs1_id_value, rs2_id_value;
  riscv_pkg::word_t rs1_ex_value, rs2_ex_value, alu_a, alu_b, alu_y, wb_value;
  riscv_pkg::reg_addr_t rs1_id, rs2_id, rd_id;
  riscv_pkg::pc_src_t pc_src;
  logic fetch_en, decode_en;

  function automatic riscv_pkg::word_t forward_mux(input riscv_pkg::forwarding_t sel,
                                                   input riscv_pkg::word_t own,
                                                   input riscv_pkg::word_t from_mem,
                                                   input riscv_pkg::word_t from_wb);
    case (sel)
      riscv_pkg::ForwardFromMem: return from_mem;
      riscv_pkg::ForwardFromWb:  return from_wb;
      default:                   return own;
    endcase
  endfunction

  // Fetch
  assign fetch_en = !stall_if && !mem_busy;
  assign decode_en = !stall_id && !mem_busy;
  assign pc_plus_4 = pc + 32'd4;
  assign inst_mem_addr = pc;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= RESET_PC;
    end else if (fetch_en) begin
      pc <= (pc_src == riscv_pkg::PcPlusImm) ? branch_target : pc_plus_4;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      if_id <= '0;
    end else if (flush_id && !mem_busy) begin
      if_id <= '0;
    end else if (decode_en) begin
      if_id.pc <= pc;
      if_id.pc_plus_4 <= pc_plus_4;
      if_id.inst <= inst;
    end
  end

  // Decode, branches and jumps resolve here
  assign id_inst = if_id.inst;
  assign rs1_id = if_id.inst[19:15];
  assign rs2_id = if_id.inst[24:20];
  assign rd_id = if_id.inst[11:7];

  register_file u_register_file (
    .clock        (clock),
    .reset        (reset),
    .write_enable (mem_wb.wr_reg_en),
    .write_address(mem_wb.rd),
    .write_data   (wb_value),
    .read_address1(rs1_id),
    .read_address2(rs2_id),
    .read_data1   (rs1_value),
    .read_data2   (rs2_value)
  );

  immediate_extender u_immediate_extender (
    .inst     (if_id.inst),
    .immediate(imm)
  );

  assign rs1_id_value = forward_mux(forward.rs1_id, rs1_value, ex_mem.alu_y, wb_value);
  assign rs2_id_value = forward_mux(forward.rs2_id, rs2_value, ex_mem.alu_y, wb_value);

  branch_decoder u_branch_decoder (
    .branch_type     (control.branch_type),
    .cond_branch_type(control.cond_branch_type),
    .read_data_1     (rs1_id_value),
    .read_data_2     (rs2_id_value),
    .pc_src          (pc_src)
  );

  assign jump_sum = rs1_id_value + imm;
  assign branch_target = (control.branch_type == riscv_pkg::JumpReg) ?
      {jump_sum[31:1], 1'b0} : if_id.pc + imm;
  assign branch_taken = pc_src == riscv_pkg::PcPlusImm;

  always_ff @(posedge clock) begin
    if (reset) begin
      id_ex <= '0;
    end else if (!mem_busy) begin
      if (flush_ex) begin
        id_ex <= '0;
      end else begin
        id_ex.pc <= if_id.pc;
        id_ex.pc_plus_4 <= if_id.pc_plus_4;
        id_ex.rs1 <= rs1_id;
        id_ex.rs2 <= rs2_id;
        id_ex.rd <= rd_id;
        id_ex.read_data_1 <= rs1_id_value;
        id_ex.read_data_2 <= rs2_id_value;
        id_ex.imm <= imm;
        id_ex.alua_src <= control.alua_src;
        id_ex.alub_src <= control.alub_src;
        id_ex.alu_op <= control.alu_op;
        id_ex.mem_rd_en <= control.mem_rd_en;
        id_ex.mem_wr_en <= control.mem_wr_en;
        id_ex.wr_reg_src <= control.wr_reg_src;
        id_ex.wr_reg_en <= control.wr_reg_en;
      end
    end
  end

  // Execute
  assign rs1_ex_value = forward_mux(forward.rs1_ex, id_ex.read_data_1, ex_mem.alu_y, wb_value);
  assign rs2_ex_value = forward_mux(forward.rs2_ex, id_ex.read_data_2, ex_mem.alu_y, wb_value);
  assign alu_a = id_ex.alua_src ? id_ex.pc : rs1_ex_value;
  assign alu_b = id_ex.alub_src ? id_ex.imm : rs2_ex_value;

  alu u_alu (
    .a     (alu_a),
    .b     (alu_b),
    .alu_op(id_ex.alu_op),
    .y     (alu_y)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_mem <= '0;
    end else if (!mem_busy) begin
      ex_mem.pc_plus_4 <= id_ex.pc_plus_4;
      ex_mem.rs2 <= id_ex.rs2;
      ex_mem.rd <= id_ex.rd;
      ex_mem.alu_y <= alu_y;
      ex_mem.write_data <= rs2_ex_value;
      ex_mem.mem_rd_en <= id_ex.mem_rd_en;
      ex_mem.mem_wr_en <= id_ex.mem_wr_en;
      ex_mem.wr_reg_src <= id_ex.wr_reg_src;
      ex_mem.wr_reg_en <= id_ex.wr_reg_en;
    end
  end

  // Memory
  assign data_mem_addr = ex_mem.alu_y;
  assign rd_en = ex_mem.mem_rd_en;
  assign wr_en = ex_mem.mem_wr_en;
  assign wr_data = forward_mux(forward.rs2_mem, ex_mem.write_data, ex_mem.alu_y, wb_value);

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_wb <= '0;
    end else if (!mem_busy) begin
      mem_wb.pc_plus_4 <= ex_mem.pc_plus_4;
      mem_wb.rd <= ex_mem.rd;
      mem_wb.alu_y <= ex_mem.alu_y;
      mem_wb.read_data <= rd_data;
      mem_wb.wr_reg_src <= ex_mem.wr_reg_src;
      mem_wb.wr_reg_en <= ex_mem.wr_reg_en;
    end
  end

  // Writeback
  always_comb begin
    case (mem_wb.wr_reg_src)
      riscv_pkg::FromMem:     wb_value = mem_wb.read_data;
      riscv_pkg::FromPcPlus4: wb_value = mem_wb.pc_plus_4;
      default:                wb_value = mem_wb.alu_y;
    endcase
  end

  always_comb begin
    hazard_view.rs1_id = rs1_id;
    hazard_view.rs2_id = rs2_id;
    hazard_view.uses_rs1_id = control.uses_rs1;
    hazard_view.uses_rs2_id = control.uses_rs2;
    hazard_view.branch_id = control.branch_type inside {riscv_pkg::CondBranch, riscv_pkg::JumpReg};
    hazard_view.rs1_ex = id_ex.rs1;
    hazard_view.rs2_ex = id_ex.rs2;
    hazard_view.rd_ex = id_ex.rd;
    hazard_view.wr_reg_en_ex = id_ex.wr_reg_en;
    hazard_view.mem_rd_en_ex = id_ex.mem_rd_en;
    hazard_view.rs2_mem = ex_mem.rs2;
    hazard_view.rd_mem = ex_mem.rd;
    hazard_view.wr_reg_en_mem = ex_mem.wr_reg_en;
    hazard_view.mem_rd_en_mem = ex_mem.mem_rd_en;
    hazard_view.rd_wb = mem_wb.rd;
    hazard_view.wr_reg_en_wb = mem_wb.wr_reg_en;
  end

endmodule

`default_nettype wire

//--- src/hazard_unit.sv
`default_nettype none

module hazard_unit (
  input  riscv_pkg::hazard_view_t hazard_view,
  input  logic                    branch_taken,
  output riscv_pkg::forward_t     forward,
  output logic                    stall_if,
  output logic                    stall_id,
  output logic                    flush_id,
  output logic                    flush_ex
);

  logic id_rs1_on_ex, id_rs2_on_ex, id_rs1_on_mem, id_rs2_on_mem;
  logic load_use, branch_wait, stall;

  // A stage produces rs when it writes a nonzero rd equal to it
  function automatic logic produces(input riscv_pkg::reg_addr_t rs, input riscv_pkg::reg_addr_t rd,
                                    input logic wr_reg_en);
    return wr_reg_en && rd != '0 && rd == rs;
  endfunction

  // Younger stage first
  function automatic riscv_pkg::forwarding_t select(input logic mem_hit, input logic wb_hit);
    if (mem_hit) return riscv_pkg::ForwardFromMem;
    if (wb_hit) return riscv_pkg::ForwardFromWb;
    return riscv_pkg::NoForwarding;
  endfunction

  always_comb begin
    forward.rs1_id = select(
        produces(hazard_view.rs1_id, hazard_view.rd_mem, hazard_view.wr_reg_en_mem),
        produces(hazard_view.rs1_id, hazard_view.rd_wb, hazard_view.wr_reg_en_wb));
    forward.rs2_id = select(
        produces(hazard_view.rs2_id, hazard_view.rd_mem, hazard_view.wr_reg_en_mem),
        produces(hazard_view.rs2_id, hazard_view.rd_wb, hazard_view.wr_reg_en_wb));
    forward.rs1_ex = select(
        produces(hazard_view.rs1_ex, hazard_view.rd_mem, hazard_view.wr_reg_en_mem),
        produces(hazard_view.rs1_ex, hazard_view.rd_wb, hazard_view.wr_reg_en_wb));
    forward.rs2_ex = select(
        produces(hazard_view.rs2_ex, hazard_view.rd_mem, hazard_view.wr_reg_en_mem),
        produces(hazard_view.rs2_ex, hazard_view.rd_wb, hazard_view.wr_reg_en_wb));
    // Store data only needs the writeback value
    forward.rs2_mem = select(1'b0,
        produces(hazard_view.rs2_mem, hazard_view.rd_wb, hazard_view.wr_reg_en_wb));
  end

  assign id_rs1_on_ex = hazard_view.uses_rs1_id &&
      produces(hazard_view.rs1_id, hazard_view.rd_ex, hazard_view.wr_reg_en_ex);
  assign id_rs2_on_ex = hazard_view.uses_rs2_id &&
      produces(hazard_view.rs2_id, hazard_view.rd_ex, hazard_view.wr_reg_en_ex);
  assign id_rs1_on_mem = hazard_view.uses_rs1_id &&
      produces(hazard_view.rs1_id, hazard_view.rd_mem, hazard_view.wr_reg_en_mem);
  assign id_rs2_on_mem = hazard_view.uses_rs2_id &&
      produces(hazard_view.rs2_id, hazard_view.rd_mem, hazard_view.wr_reg_en_mem);

  assign load_use = hazard_view.mem_rd_en_ex && (id_rs1_on_ex || id_rs2_on_ex);

  // Decode-stage compare cannot see execute results or load data in memory
  assign branch_wait = hazard_view.branch_id && (id_rs1_on_ex || id_rs2_on_ex ||
      (hazard_view.mem_rd_en_mem && (id_rs1_on_mem || id_rs2_on_mem)));

  assign stall = load_use || branch_wait;
  assign stall_if = stall;
  assign stall_id = stall;
  assign flush_ex = stall;
  assign flush_id = branch_taken && !stall;

endmodule

`default_nettype wire

//--- src/immediate_extender.sv
`default_nettype none

module immediate_extender (
  input  riscv_pkg::instruction_t inst,
  output riscv_pkg::word_t        immediate
);

  always_comb begin
    case (riscv_pkg::opcode_t'(inst[6:0]))
      riscv_pkg::Lui, riscv_pkg::Auipc: begin
        immediate = {inst[31:12], 12'b0};
      end
      riscv_pkg::Jal: begin
        immediate = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      riscv_pkg::Branch: begin
        immediate = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      riscv_pkg::Store: begin
        immediate = {{21{inst[31]}}, inst[30:25], inst[11:7]};
      end
      default: begin
        // I format, also JALR and loads
        immediate = {{21{inst[31]}}, inst[30:20]};
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/register_file.sv
`default_nettype none

module register_file (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 write_enable,
  input  riscv_pkg::reg_addr_t write_address,
  input  riscv_pkg::word_t     write_data,
  input  riscv_pkg::reg_addr_t read_address1,
  input  riscv_pkg::reg_addr_t read_address2,
  output riscv_pkg::word_t     read_data1,
  output riscv_pkg::word_t     read_data2
);

  riscv_pkg::word_t regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      regs <= '{default: '0};
    end else if (write_enable && write_address != '0) begin
      regs[write_address] <= write_data;
    end
  end

  // x0 is hardwired
  assign read_data1 = (read_address1 == '0) ? '0 : regs[read_address1];
  assign read_data2 = (read_address2 == '0) ? '0 : regs[read_address2];

endmodule

`default_nettype wire

//--- src/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [31:0] instruction_t;

  typedef enum logic [6:0] {
    Lui    = 7'b0110111,
    Auipc  = 7'b0010111,
    Jal    = 7'b1101111,
    Jalr   = 7'b1100111,
    Branch = 7'b1100011,
    Load   = 7'b0000011,
    Store  = 7'b0100011,
    OpImm  = 7'b0010011,
    Op     = 7'b0110011
  } opcode_t;

  typedef enum logic [3:0] {
    Add, Sub, Sll, Slt, Sltu, Xor, Srl, Sra, Or, And, PassB
  } alu_op_t;

  typedef enum logic [1:0] {NoBranch, CondBranch, JumpPc, JumpReg} branch_t;

  // Encoded as the funct3 field of the branch
  typedef enum logic [2:0] {
    Beq  = 3'b000,
    Bne  = 3'b001,
    Blt  = 3'b100,
    Bge  = 3'b101,
    Bltu = 3'b110,
    Bgeu = 3'b111
  } cond_branch_t;

  typedef enum logic {PcPlus4, PcPlusImm} pc_src_t;

  typedef enum logic [1:0] {FromAlu, FromMem, FromPcPlus4} wr_reg_src_t;

  typedef enum logic [1:0] {
    NoForwarding, ForwardFromEx, ForwardFromMem, ForwardFromWb
  } forwarding_t;

  // All zero is a no-op
  typedef struct packed {
    logic         alua_src;
    logic         alub_src;
    alu_op_t      alu_op;
    wr_reg_src_t  wr_reg_src;
    logic         wr_reg_en;
    logic         mem_rd_en;
    logic         mem_wr_en;
    branch_t      branch_type;
    cond_branch_t cond_branch_type;
    logic         uses_rs1;
    logic         uses_rs2;
  } control_t;

  typedef struct packed {
    word_t        pc;
    word_t        pc_plus_4;
    instruction_t inst;
  } if_id_t;

  typedef struct packed {
    word_t       pc;
    word_t       pc_plus_4;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    word_t       read_data_1;
    word_t       read_data_2;
    word_t       imm;
    logic        alua_src;
    logic        alub_src;
    alu_op_t     alu_op;
    logic        mem_rd_en;
    logic        mem_wr_en;
    wr_reg_src_t wr_reg_src;
    logic        wr_reg_en;
  } id_ex_t;

  typedef struct packed {
    word_t       pc_plus_4;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    word_t       alu_y;
    word_t       write_data;
    logic        mem_rd_en;
    logic        mem_wr_en;
    wr_reg_src_t wr_reg_src;
    logic        wr_reg_en;
  } ex_mem_t;

  typedef struct packed {
    word_t       pc_plus_4;
    reg_addr_t   rd;
    word_t       alu_y;
    word_t       read_data;
    wr_reg_src_t wr_reg_src;
    logic        wr_reg_en;
  } mem_wb_t;

  typedef struct packed {
    forwarding_t rs1_id;
    forwarding_t rs2_id;
    forwarding_t rs1_ex;
    forwarding_t rs2_ex;
    forwarding_t rs2_mem;
  } forward_t;

  typedef struct packed {
    reg_addr_t rs1_id;
    reg_addr_t rs2_id;
    logic      uses_rs1_id;
    logic      uses_rs2_id;
    logic      branch_id;     // conditional branch or JALR in decode
    reg_addr_t rs1_ex;
    reg_addr_t rs2_ex;
    reg_addr_t rd_ex;
    logic      wr_reg_en_ex;
    logic      mem_rd_en_ex;
    reg_addr_t rs2_mem;
    reg_addr_t rd_mem;
    logic      wr_reg_en_mem;
    logic      mem_rd_en_mem;
    reg_addr_t rd_wb;
    logic      wr_reg_en_wb;
  } hazard_view_t;

endpackage

`default_nettype wire

//--- test/core_tb.sv
`default_nettype none

module core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam riscv_pkg::word_t RESET_PC = '0;
  localparam riscv_pkg::word_t GUARD = 32'h7f0;
  localparam riscv_pkg::word_t DONE = 32'h7f8;

  logic clock, reset, rd_en, wr_en, mem_busy, busy_enable;
  riscv_pkg::instruction_t inst;
  riscv_pkg::word_t inst_mem_addr, rd_data, data_mem_addr, wr_data;

  // Reference machine state used while the program is assembled
  riscv_pkg::word_t regs [32];
  riscv_pkg::word_t expected [riscv_pkg::word_t];
  riscv_pkg::word_t data_model [riscv_pkg::word_t];
  bit seen [riscv_pkg::word_t];
  riscv_pkg::word_t pc, next_addr;
  int instr_count, stores_seen, cycles, cycle_limit;

  core_top #(.RESET_PC(RESET_PC)) dut (
    .clock(clock), .reset(reset), .inst(inst), .inst_mem_addr(inst_mem_addr),
    .rd_data(rd_data), .data_mem_addr(data_mem_addr), .wr_data(wr_data),
    .rd_en(rd_en), .wr_en(wr_en), .mem_busy(mem_busy)
  );

  tb_memory mem (
    .clock(clock), .busy_enable(busy_enable), .inst_addr(inst_mem_addr), .inst(inst),
    .data_addr(data_mem_addr), .wr_data(wr_data), .wr_en(wr_en), .rd_en(rd_en),
    .rd_data(rd_data), .mem_busy(mem_busy)
  );

  function automatic bit store_matches(input riscv_pkg::word_t addr, input riscv_pkg::word_t d);
    return expected.exists(addr) && expected[addr] == d;
  endfunction

  store_value: assert property (@(posedge clock) disable iff (reset)
      wr_en |-> store_matches(data_mem_addr, wr_data))
    else begin
      if (!expected.exists($sampled(data_mem_addr))) begin
        $display("Store to address %h that the program never reaches", $sampled(data_mem_addr));
      end else begin
        $display("** Error at %0t ns: wr_data at %h expected %h actual %h", $time,
                 $sampled(data_mem_addr), expected[$sampled(data_mem_addr)], $sampled(wr_data));
      end
      $display("Simulation failed");
      $fatal(1);
    end

  // Reset values hold through reset and the first cycle after it
  reset_state: assert property (@(posedge clock)
      $past(reset) |-> (!wr_en && !rd_en && inst_mem_addr == RESET_PC))
    else begin
      $display("Memory enables or fetch address wrong during reset or the cycle after it");
      $display("Simulation failed");
      $fatal(1);
    end

  busy_hold: assert property (@(posedge clock) disable iff (reset)
      mem_busy |=> $stable(inst_mem_addr))
    else begin
      $display("Fetch address moved while mem_busy was high");
      $display("Simulation failed");
      $fatal(1);
    end

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("Timeout after %0d cycles with %0d stores seen", cycles, stores_seen);
      $display("Simulation failed");
      $fatal(1);
    end
    if (!reset && wr_en && expected.exists(data_mem_addr) && !seen.exists(data_mem_addr)) begin
      seen[data_mem_addr] = 1'b1;
      stores_seen++;
    end
  end

  // RV32I arithmetic as defined by the ISA
  function automatic riscv_pkg::word_t alu_ref(input logic [2:0] f3, input bit alt,
                                               input riscv_pkg::word_t a,
                                               input riscv_pkg::word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic bit branch_ref(input logic [2:0] f3, input riscv_pkg::word_t a,
                                    input riscv_pkg::word_t b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic put(input riscv_pkg::instruction_t word);
    mem.load_word(int'(pc >> 2), word);
    pc += 4;
    instr_count++;
  endtask

  task automatic set_reg(input int rd, input riscv_pkg::word_t value);
    if (rd != 0) regs[rd] = value;
  endtask

  task automatic op_r(input logic [2:0] f3, input bit alt, input int rd, input int rs1,
                      input int rs2);
    put({1'b0, alt, 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011});
    set_reg(rd, alu_ref(f3, alt, regs[rs1], regs[rs2]));
  endtask

  task automatic op_i(input logic [2:0] f3, input int rd, input int rs1, input logic [11:0] imm);
    bit alt;
    alt = (f3 == 3'd5) && imm[10];
    put({imm, 5'(rs1), f3, 5'(rd), 7'b0010011});
    set_reg(rd, alu_ref(f3, alt, regs[rs1], {{20{imm[11]}}, imm}));
  endtask

  task automatic li(input int rd, input riscv_pkg::word_t value);
    riscv_pkg::word_t upper;
    riscv_pkg::word_t lower;
    upper = (value + 32'h800) >> 12;
    lower = value - (upper << 12);
    put({upper[19:0], 5'(rd), 7'b0110111});
    set_reg(rd, upper << 12);
    op_i(3'd0, rd, rd, lower[11:0]);
  endtask

  task automatic store_at(input riscv_pkg::word_t addr, input int rs2);
    put({addr[11:5], 5'(rs2), 5'd0, 3'b010, addr[4:0], 7'b0100011});
  endtask

  task automatic check_store(input int rs2);
    store_at(next_addr, rs2);
    expected[next_addr] = regs[rs2];
    data_model[next_addr] = regs[rs2];
    next_addr += 4;
  endtask

  task automatic load(input int rd, input riscv_pkg::word_t addr);
    put({addr[11:0], 5'd0, 3'b010, 5'(rd), 7'b0000011});
    set_reg(rd, data_model[addr]);
  endtask

  task automatic branch_case(input logic [2:0] f3, input riscv_pkg::word_t a,
                             input riscv_pkg::word_t b);
    li(1, a);
    li(2, b);
    put({1'b0, 6'd0, 5'd2, 5'd1, f3, 4'd4, 1'b0, 7'b1100011});
    // Slot behind the branch holds poison when taken
    if (branch_ref(f3, a, b)) store_at(GUARD, 31);
    else check_store(30);
  endtask

  task automatic dep_chain(input riscv_pkg::word_t v);
    li(5, v);
    op_i(3'd0, 6, 5, 12'd7);
    op_i(3'd0, 7, 5, 12'd9);
    op_i(3'd0, 8, 5, 12'd11);
    op_i(3'd0, 12, 5, 12'd13);
    op_r(3'd0, 1'b0, 9, 8, 7);
    op_r(3'd0, 1'b1, 10, 9, 6);
    op_r(3'd0, 1'b0, 11, 10, 10);
    for (int r = 6; r <= 12; r++) check_store(r);
  endtask

  task automatic build_program();
    riscv_pkg::word_t a_addr, here;
    logic [2:0] kinds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    riscv_pkg::word_t pairs [8] = '{5, 5, 5, 7, -3, 2, 2, -3};
    li(31, 32'hdeadbeef);
    li(30, 32'h600d0001);
    for (int k = 0; k < 4; k++) begin
      li(1, $urandom);
      li(2, $urandom);
      for (int f = 0; f < 8; f++) begin
        op_r(3'(f), 1'b0, 3, 1, 2);
        check_store(3);
        op_i(3'(f), 4, 1, (f == 1 || f == 5) ? 12'($urandom_range(31)) : 12'($urandom));
        check_store(4);
      end
      op_r(3'd0, 1'b1, 3, 1, 2);
      check_store(3);
      op_r(3'd5, 1'b1, 3, 1, 2);
      check_store(3);
      op_i(3'd5, 4, 1, 12'h400 | 12'($urandom_range(31)));
      check_store(4);
    end
    here = pc;
    put({20'h12345, 5'd15, 7'b0010111});
    set_reg(15, here + 32'h12345000);
    check_store(15);
    for (int k = 0; k < 3; k++) dep_chain($urandom);
    // Load used at once and load data stored at once
    op_i(3'd4, 16, 11, 12'h5a5);
    a_addr = next_addr;
    check_store(16);
    load(17, a_addr);
    op_i(3'd0, 18, 17, 12'd5);
    check_store(18);
    load(19, a_addr);
    check_store(19);
    for (int k = 0; k < 6; k++) begin
      for (int p = 0; p < 4; p++) branch_case(kinds[k], pairs[2 * p], pairs[2 * p + 1]);
    end
    here = pc;
    put({1'b0, 10'd4, 1'b0, 8'd0, 5'd20, 7'b1101111});
    set_reg(20, here + 4);
    store_at(GUARD, 31);
    check_store(20);
    li(21, pc + 12);
    here = pc;
    put({12'd4, 5'd21, 3'b000, 5'd22, 7'b1100111});
    set_reg(22, here + 4);
    store_at(GUARD, 31);
    check_store(22);
    // Marker store ends the program
    store_at(DONE, 30);
    expected[DONE] = regs[30];
    put({1'b0, 10'd0, 1'b0, 8'd0, 5'd0, 7'b1101111});
  endtask

  task automatic run_phase(input bit with_busy);
    reset = 1'b1;
    busy_enable = 1'b0;
    repeat (3) @(negedge clock);
    seen.delete();
    stores_seen = 0;
    reset = 1'b0;
    @(posedge clock);
    busy_enable = with_busy;
    while (!seen.exists(DONE)) @(negedge clock);
    foreach (expected[addr]) begin
      if (!seen.exists(addr)) begin
        $display("No store reached address %h before the end of the program", addr);
        $display("Simulation failed");
        $fatal(1);
      end
    end
  endtask

  initial begin
    void'($urandom(32'hb34a8d6d));
    reset = 1'b1;
    busy_enable = 1'b0;
    cycles = 0;
    cycle_limit = 0;
    pc = RESET_PC;
    next_addr = 32'h100;
    instr_count = 0;
    for (int r = 0; r < 32; r++) regs[r] = '0;
    mem.fill_patterns();
    build_program();
    cycle_limit = 4 * (2 * instr_count) + 200;
    run_phase(1'b0);
    run_phase(1'b1);
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/tb_memory.sv
`default_nettype none

module tb_memory (
  input  logic                    clock,
  input  logic                    busy_enable,
  input  riscv_pkg::word_t        inst_addr,
  output riscv_pkg::instruction_t inst,
  input  riscv_pkg::word_t        data_addr,
  input  riscv_pkg::word_t        wr_data,
  input  logic                    wr_en,
  input  logic                    rd_en,
  output riscv_pkg::word_t        rd_data,
  output logic                    mem_busy
);
  timeunit 1ns;
  timeprecision 100ps;

  riscv_pkg::word_t rom [512];
  riscv_pkg::word_t ram [512];

  initial begin
    mem_busy = 1'b0;
  end

  // Opcode field zero makes unused words decode as no-ops
  task automatic fill_patterns();
    for (int i = 0; i < 512; i++) begin
      rom[i] = 32'(i) << 7;
      ram[i] = 32'h5a5a0000 ^ 32'(i);
    end
  endtask

  task automatic load_word(input int index, input riscv_pkg::word_t word);
    rom[index] = word;
  endtask

  assign inst = rom[inst_addr[10:2]];
  // Read data is only valid with the read enable
  assign rd_data = rd_en ? ram[data_addr[10:2]] : '0;

  // A store repeated under busy writes the same word again
  always @(posedge clock) begin
    if (wr_en) begin
      ram[data_addr[10:2]] <= wr_data;
    end
  end

  always @(negedge clock) begin
    mem_busy <= busy_enable ? ($urandom_range(3) == 0) : 1'b0;
  end

endmodule

`default_nettype wire
